// ==== ppu_top.f ====
source/ppu_timing_pkg.sv
source/ppu_regs_pkg.sv
source/ppu_registers.sv
source/lcd_timing.sv
source/sprite_slot.sv
source/sprite_priority.sv
source/ppu_top.sv
tests/clock_gen.sv
tests/ppu_assertions.sv
tests/ppu_tb.sv

// ==== run.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module ppu_tb -f ppu_top.f -o ppu_sim
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

output=$(./obj_dir/ppu_sim)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation returned status $status"
    exit 1
fi

if grep -qx "Everything OK" <<< "$output"; then
    exit 0
else
    exit 1
fi

// ==== source/lcd_timing.sv ====
`timescale 1ns/1ps

module lcd_timing (
    input  logic                         clockgb,
    input  logic                         resetn,
    input  ppu_regs_pkg::lcd_ctrl_t      lcd_ctrl,
    input  logic [3:0]                   stat_sources,
    input  ppu_timing_pkg::pixel_coord_t lyc,
    output ppu_timing_pkg::pixel_coord_t ly,
    output ppu_timing_pkg::mode_t        mode,
    output logic                         coincidence,
    output ppu_timing_pkg::pixel_pos_t   pixel_pos,
    output logic                         vblank_int,
    output logic                         lcdc_int
);

    ppu_timing_pkg::mode_t        state_q;
    logic [7:0]                   cnt_q;
    ppu_timing_pkg::pixel_coord_t x_q;
    logic                         hblank_first;
    logic                         vblank_line;

    always_ff @(posedge clockgb or negedge resetn) begin
        if (!resetn) begin
            state_q <= ppu_timing_pkg::mode_oam_scan;
            cnt_q   <= '0;
            x_q     <= '0;
            ly      <= '0;
        end else if (!lcd_ctrl.enable) begin
            state_q <= ppu_timing_pkg::mode_oam_scan;   // Held idle while display off
            cnt_q   <= '0;
            x_q     <= '0;
            ly      <= '0;
        end else begin
            case (state_q)
                ppu_timing_pkg::mode_oam_scan: begin
                    if (cnt_q == 8'(ppu_timing_pkg::oam_scan_cycles - 1)) begin
                        state_q <= ppu_timing_pkg::mode_drawing;
                        cnt_q   <= '0;
                        x_q     <= '0;
                    end else begin
                        cnt_q <= cnt_q + 8'd1;
                    end
                end
                ppu_timing_pkg::mode_drawing: begin
                    if (x_q != 8'(ppu_timing_pkg::screen_width - 1)) begin
                        x_q <= x_q + 8'd1;
                    end
                    if (cnt_q == 8'(ppu_timing_pkg::draw_cycles - 1)) begin
                        state_q <= ppu_timing_pkg::mode_hblank;
                        cnt_q   <= '0;
                    end else begin
                        cnt_q <= cnt_q + 8'd1;
                    end
                end
                ppu_timing_pkg::mode_hblank: begin
                    if (cnt_q == 8'(ppu_timing_pkg::hblank_cycles - 1)) begin
                        state_q <= ppu_timing_pkg::mode_oam_scan;
                        cnt_q   <= '0;
                        if (ly == 8'(ppu_timing_pkg::line_count - 1)) begin
                            ly <= '0;
                        end else begin
                            ly <= ly + 8'd1;
                        end
                    end else begin
                        cnt_q <= cnt_q + 8'd1;
                    end
                end
                default: state_q <= ppu_timing_pkg::mode_oam_scan;
            endcase
        end
    end

    assign coincidence = (ly == lyc);
    assign vblank_line = (ly == 8'(ppu_timing_pkg::screen_height));
    assign hblank_first = (state_q == ppu_timing_pkg::mode_hblank) && (cnt_q == '0);

    // Lines past the visible area report vblank
    assign mode = (ly >= 8'(ppu_timing_pkg::screen_height)) ?
                  ppu_timing_pkg::mode_vblank : state_q;

    assign pixel_pos.valid = (state_q == ppu_timing_pkg::mode_drawing) &&
                             (cnt_q < 8'(ppu_timing_pkg::screen_width)) &&
                             (ly < 8'(ppu_timing_pkg::screen_height));
    assign pixel_pos.x = x_q;
    assign pixel_pos.y = ly;

    assign vblank_int = hblank_first && vblank_line;

    always_comb begin
        lcdc_int = 1'b0;
        if (state_q == ppu_timing_pkg::mode_drawing &&
            cnt_q == 8'(ppu_timing_pkg::draw_cycles - 1) && stat_sources[0]) begin
            lcdc_int = 1'b1;                // End of drawing
        end
        if (state_q == ppu_timing_pkg::mode_hblank &&
            cnt_q == 8'(ppu_timing_pkg::hblank_cycles - 1) && stat_sources[2]) begin
            lcdc_int = 1'b1;                // End of line
        end
        if (hblank_first && ((stat_sources[3] && coincidence) ||
                             (stat_sources[1] && vblank_line))) begin
            lcdc_int = 1'b1;
        end
    end

endmodule

// ==== source/ppu_registers.sv ====
`timescale 1ns/1ps

module ppu_registers (
    input  logic                        clockgb,
    input  logic                        resetn,
    input  ppu_regs_pkg::bus_addr_t     address,
    input  ppu_regs_pkg::bus_data_t     indata,
    input  logic                        load,
    input  logic                        store,
    output ppu_regs_pkg::bus_data_t     outdata,
    input  ppu_timing_pkg::pixel_coord_t ly,
    input  ppu_timing_pkg::mode_t       mode,
    input  logic                        coincidence,
    output ppu_regs_pkg::lcd_ctrl_t     lcd_ctrl,
    output logic [3:0]                  stat_sources,
    output ppu_timing_pkg::pixel_coord_t lyc,
    output ppu_regs_pkg::oam_entry_t    oam [ppu_regs_pkg::sprite_count]
);

    ppu_regs_pkg::bus_data_t     lcdc_q;
    logic [7:3]                  stat_q;    // Writable part of STAT
    ppu_regs_pkg::bus_data_t     rd_data;
    logic                        in_oam;
    logic [7:0]                  oam_offset;
    ppu_regs_pkg::sprite_index_t oam_idx;
    logic [1:0]                  oam_sel;

    assign in_oam     = (address >= ppu_regs_pkg::oam_base) &&
                        (address <= ppu_regs_pkg::oam_last);
    assign oam_offset = 8'(address - ppu_regs_pkg::oam_base);
    assign oam_idx    = oam_offset[7:2];
    assign oam_sel    = oam_offset[1:0];

    assign lcd_ctrl.enable     = lcdc_q[ppu_regs_pkg::lcdc_enable_bit];
    assign lcd_ctrl.tall       = lcdc_q[ppu_regs_pkg::lcdc_tall_bit];
    assign lcd_ctrl.sprites_on = lcdc_q[ppu_regs_pkg::lcdc_sprites_bit];

    // Order: coincidence, line end, vblank, hblank
    assign stat_sources = {stat_q[ppu_regs_pkg::stat_coin_bit],
                           stat_q[ppu_regs_pkg::stat_line_end_bit],
                           stat_q[ppu_regs_pkg::stat_vblank_bit],
                           stat_q[ppu_regs_pkg::stat_hblank_bit]};

    always_ff @(posedge clockgb or negedge resetn) begin
        if (!resetn) begin
            lcdc_q <= ppu_regs_pkg::lcdc_reset;
            stat_q <= '0;
            lyc    <= '0;
        end else if (store) begin
            case (address)
                ppu_regs_pkg::lcdc_addr: lcdc_q <= indata;
                ppu_regs_pkg::stat_addr: stat_q <= indata[7:3];
                ppu_regs_pkg::lyc_addr:  lyc    <= indata;
                default: ;                  // LY is read only
            endcase
        end
    end

    always_ff @(posedge clockgb) begin
        if (store && in_oam) begin
            case (oam_sel)
                2'd0: oam[oam_idx].y    <= indata;
                2'd1: oam[oam_idx].x    <= indata;
                2'd2: oam[oam_idx].tile <= indata;
                default: oam[oam_idx].attr <= indata;
            endcase
        end
    end

    always_comb begin
        rd_data = '0;
        if (in_oam) begin
            case (oam_sel)
                2'd0: rd_data = oam[oam_idx].y;
                2'd1: rd_data = oam[oam_idx].x;
                2'd2: rd_data = oam[oam_idx].tile;
                default: rd_data = oam[oam_idx].attr;
            endcase
        end else begin
            case (address)
                ppu_regs_pkg::lcdc_addr: rd_data = lcdc_q;
                ppu_regs_pkg::stat_addr: rd_data = {stat_q, coincidence, mode};
                ppu_regs_pkg::ly_addr:   rd_data = ly;
                ppu_regs_pkg::lyc_addr:  rd_data = lyc;
                default:                 rd_data = '0;
            endcase
        end
    end

    // Read data valid for one cycle only
    always_ff @(posedge clockgb or negedge resetn) begin
        if (!resetn) begin
            outdata <= '0;
        end else begin
            outdata <= load ? rd_data : '0;
        end
    end

endmodule

// ==== source/ppu_regs_pkg.sv ====
package ppu_regs_pkg;

    typedef logic [15:0] bus_addr_t;
    typedef logic [7:0]  bus_data_t;

    // Register map
    localparam bus_addr_t lcdc_addr = 16'hff40;
    localparam bus_addr_t stat_addr = 16'hff41;
    localparam bus_addr_t ly_addr   = 16'hff44;
    localparam bus_addr_t lyc_addr  = 16'hff45;
    localparam bus_addr_t oam_base  = 16'hfe00;
    localparam bus_addr_t oam_last  = 16'hfe9f;

    localparam int sprite_count = 40;
    typedef logic [5:0] sprite_index_t;

    localparam bus_data_t lcdc_reset = 8'h91;

    // LCDC bits
    localparam int lcdc_enable_bit  = 7;
    localparam int lcdc_tall_bit    = 2;
    localparam int lcdc_sprites_bit = 1;

    // STAT interrupt source bits
    localparam int stat_hblank_bit   = 3;
    localparam int stat_vblank_bit   = 4;
    localparam int stat_line_end_bit = 5;
    localparam int stat_coin_bit     = 6;

    // One OAM entry, byte 0 first
    typedef struct packed {
        bus_data_t y;
        bus_data_t x;
        bus_data_t tile;
        bus_data_t attr;                    // 7 behind, 6 y flip, 5 x flip, 4 palette
    } oam_entry_t;

    typedef struct packed {
        logic enable;
        logic tall;
        logic sprites_on;
    } lcd_ctrl_t;

    typedef struct packed {
        logic      hit;
        logic [2:0] fine_x;
        logic [3:0] fine_y;
        bus_data_t tile;
        logic      palette;
        logic      behind;
    } sprite_hit_t;

    typedef struct packed {
        ppu_timing_pkg::pixel_pos_t pos;
        sprite_index_t              index;
        sprite_hit_t                sprite;
    } sprite_pixel_t;

endpackage

// ==== source/ppu_timing_pkg.sv ====
package ppu_timing_pkg;

    // Visible area and frame size
    localparam int screen_width  = 160;
    localparam int screen_height = 144;
    localparam int line_count    = 154;

    // Cycles spent in each mode of a line, 456 in total
    localparam int oam_scan_cycles = 80;
    localparam int draw_cycles     = 171;
    localparam int hblank_cycles   = 205;

    typedef logic [7:0] pixel_coord_t;      // Screen x or line number

    // Encodings as reported in STAT
    typedef enum logic [1:0] {
        mode_hblank   = 2'd0,
        mode_vblank   = 2'd1,
        mode_oam_scan = 2'd2,
        mode_drawing  = 2'd3
    } mode_t;

    typedef struct packed {
        logic         valid;
        pixel_coord_t x;
        pixel_coord_t y;
    } pixel_pos_t;

endpackage

// ==== source/ppu_top.sv ====
`timescale 1ns/1ps

module ppu_top (
    input  logic                        clockgb,
    input  logic                        resetn,
    input  ppu_regs_pkg::bus_addr_t     address,
    input  ppu_regs_pkg::bus_data_t     indata,
    input  logic                        load,
    input  logic                        store,
    output ppu_regs_pkg::bus_data_t     outdata,
    output logic                        vblank_int,
    output logic                        lcdc_int,
    output ppu_regs_pkg::sprite_pixel_t sprite_pixel
);

    ppu_regs_pkg::lcd_ctrl_t      lcd_ctrl;
    logic [3:0]                   stat_sources;
    ppu_timing_pkg::pixel_coord_t lyc;
    ppu_timing_pkg::pixel_coord_t ly;
    ppu_timing_pkg::mode_t        mode;
    logic                         coincidence;
    ppu_timing_pkg::pixel_pos_t   pixel_pos;
    ppu_regs_pkg::oam_entry_t     oam [ppu_regs_pkg::sprite_count];
    ppu_regs_pkg::sprite_hit_t    hits [ppu_regs_pkg::sprite_count];

    ppu_registers u_registers (
        .clockgb      (clockgb),
        .resetn       (resetn),
        .address      (address),
        .indata       (indata),
        .load         (load),
        .store        (store),
        .outdata      (outdata),
        .ly           (ly),
        .mode         (mode),
        .coincidence  (coincidence),
        .lcd_ctrl     (lcd_ctrl),
        .stat_sources (stat_sources),
        .lyc          (lyc),
        .oam          (oam)
    );

    lcd_timing u_timing (
        .clockgb      (clockgb),
        .resetn       (resetn),
        .lcd_ctrl     (lcd_ctrl),
        .stat_sources (stat_sources),
        .lyc          (lyc),
        .ly           (ly),
        .mode         (mode),
        .coincidence  (coincidence),
        .pixel_pos    (pixel_pos),
        .vblank_int   (vblank_int),
        .lcdc_int     (lcdc_int)
    );

    for (genvar i = 0; i < ppu_regs_pkg::sprite_count; i++) begin : g_slot
        sprite_slot u_slot (
            .clockgb   (clockgb),
            .resetn    (resetn),
            .pixel_pos (pixel_pos),
            .entry     (oam[i]),
            .tall      (lcd_ctrl.tall),
            .hit       (hits[i])
        );
    end

    sprite_priority u_priority (
        .clockgb      (clockgb),
        .resetn       (resetn),
        .pixel_pos    (pixel_pos),
        .sprites_on   (lcd_ctrl.sprites_on),
        .hits         (hits),
        .sprite_pixel (sprite_pixel)
    );

endmodule

// ==== source/sprite_priority.sv ====
`timescale 1ns/1ps

module sprite_priority (
    input  logic                        clockgb,
    input  logic                        resetn,
    input  ppu_timing_pkg::pixel_pos_t  pixel_pos,
    input  logic                        sprites_on,
    input  ppu_regs_pkg::sprite_hit_t   hits [ppu_regs_pkg::sprite_count],
    output ppu_regs_pkg::sprite_pixel_t sprite_pixel
);

    ppu_timing_pkg::pixel_pos_t  pos_d;     // Lines up with slot outputs
    ppu_regs_pkg::sprite_hit_t   sel_hit;
    ppu_regs_pkg::sprite_index_t sel_index;

    // Walk downwards so the lowest index wins
    always_comb begin
        sel_hit   = '0;
        sel_index = '0;
        if (sprites_on) begin
            for (int i = ppu_regs_pkg::sprite_count - 1; i >= 0; i--) begin
                if (hits[i].hit) begin
                    sel_hit   = hits[i];
                    sel_index = ppu_regs_pkg::sprite_index_t'(i);
                end
            end
        end
    end

    always_ff @(posedge clockgb or negedge resetn) begin
        if (!resetn) begin
            pos_d        <= '0;
            sprite_pixel <= '0;
        end else begin
            pos_d               <= pixel_pos;
            sprite_pixel.pos    <= pos_d;
            sprite_pixel.index  <= sel_index;
            sprite_pixel.sprite <= sel_hit;
        end
    end

endmodule

// ==== source/sprite_slot.sv ====
`timescale 1ns/1ps

module sprite_slot (
    input  logic                       clockgb,
    input  logic                       resetn,
    input  ppu_timing_pkg::pixel_pos_t pixel_pos,
    input  ppu_regs_pkg::oam_entry_t   entry,
    input  logic                       tall,
    output ppu_regs_pkg::sprite_hit_t  hit
);

    logic [8:0]                sx;          // Screen x in OAM space
    logic [8:0]                sy;
    logic [8:0]                h;
    logic [8:0]                dx;
    logic [8:0]                dy;
    logic                      x_match;
    logic                      y_match;
    ppu_regs_pkg::sprite_hit_t hit_d;

    assign sx = {1'b0, pixel_pos.x} + 9'd8;
    assign sy = {1'b0, pixel_pos.y} + 9'd16;
    assign h  = tall ? 9'd16 : 9'd8;
    assign dx = sx - {1'b0, entry.x};
    assign dy = sy - {1'b0, entry.y};

    assign x_match = (sx >= {1'b0, entry.x}) && (sx < {1'b0, entry.x} + 9'd8);
    assign y_match = (sy >= {1'b0, entry.y}) && (sy < {1'b0, entry.y} + h);

    always_comb begin
        hit_d.hit     = pixel_pos.valid && x_match && y_match;
        hit_d.fine_x  = entry.attr[5] ? 3'd7 - dx[2:0] : dx[2:0];
        hit_d.fine_y  = entry.attr[6] ? 4'(h - 9'd1) - dy[3:0] : dy[3:0];
        hit_d.tile    = entry.tile;
        hit_d.palette = entry.attr[4];
        hit_d.behind  = entry.attr[7];
    end

    always_ff @(posedge clockgb or negedge resetn) begin
        if (!resetn) begin
            hit <= '0;
        end else begin
            hit <= hit_d;
        end
    end

endmodule

// ==== tests/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen (
    output logic clockgb,
    output logic resetn
);

    initial begin
        clockgb = 1'b0;
        forever #4 clockgb = ~clockgb;      // 8 ns period
    end

    initial begin
        resetn = 1'b0;
        repeat (5) @(posedge clockgb);
        @(negedge clockgb);
        resetn = 1'b1;
    end

endmodule

// ==== tests/ppu_assertions.sv ====
`timescale 1ns/1ps

module ppu_assertions (
    input logic                         clockgb,
    input logic                         resetn,
    input ppu_timing_pkg::pixel_coord_t ly,
    input ppu_timing_pkg::mode_t        mode,
    input ppu_timing_pkg::mode_t        state_q,
    input logic [7:0]                   cnt_q,
    input ppu_timing_pkg::pixel_pos_t   pixel_pos,
    input logic                         vblank_int
);

    a_no_early_vblank: assert property (@(posedge clockgb) disable iff (!resetn)
        (ly < 8'(ppu_timing_pkg::screen_height)) |-> (mode != ppu_timing_pkg::mode_vblank))
        else $error("mode is vblank on a visible line");

    // Pixel x tracks the drawing cycle count
    a_valid_in_drawing: assert property (@(posedge clockgb) disable iff (!resetn)
        pixel_pos.valid |-> (state_q == ppu_timing_pkg::mode_drawing) &&
                            (pixel_pos.x == cnt_q))
        else $error("pixel strobe outside drawing or off its drawing cycle");

    a_vblank_single: assert property (@(posedge clockgb) disable iff (!resetn)
        vblank_int |=> !vblank_int)
        else $error("vblank pulse longer than one cycle");

endmodule

bind lcd_timing ppu_assertions u_assertions (
    .clockgb    (clockgb),
    .resetn     (resetn),
    .ly         (ly),
    .mode       (mode),
    .state_q    (state_q),
    .cnt_q      (cnt_q),
    .pixel_pos  (pixel_pos),
    .vblank_int (vblank_int)
);

// ==== tests/ppu_tb.sv ====
`timescale 1ns/1ps

module ppu_tb;

    localparam int line_cycles = ppu_timing_pkg::oam_scan_cycles +
                                 ppu_timing_pkg::draw_cycles + ppu_timing_pkg::hblank_cycles;
    localparam int frame_cycles  = line_cycles * ppu_timing_pkg::line_count;
    localparam int timeout_limit = 3 * frame_cycles + 10000;
    localparam int frame_pixels  = ppu_timing_pkg::screen_width * ppu_timing_pkg::screen_height;

    logic                        clockgb;
    logic                        resetn;
    ppu_regs_pkg::bus_addr_t     address;
    ppu_regs_pkg::bus_data_t     indata;
    logic                        load;
    logic                        store;
    ppu_regs_pkg::bus_data_t     outdata;
    logic                        vblank_int;
    logic                        lcdc_int;
    ppu_regs_pkg::sprite_pixel_t sprite_pixel;

    ppu_regs_pkg::bus_data_t oam_copy [160];
    ppu_regs_pkg::bus_data_t lcdc_copy;
    logic [31:0]             lfsr_state = 32'hc578;
    int cycles = 0;
    int vb_count = 0;
    int lcdc_count = 0;
    int last_vb = 0;
    int pix_count = 0;
    int exp_x = 0;
    int exp_y = 0;

    clock_gen u_clock (.clockgb(clockgb), .resetn(resetn));

    ppu_top dut0 (
        .clockgb      (clockgb),
        .resetn       (resetn),
        .address      (address),
        .indata       (indata),
        .load         (load),
        .store        (store),
        .outdata      (outdata),
        .vblank_int   (vblank_int),
        .lcdc_int     (lcdc_int),
        .sprite_pixel (sprite_pixel)
    );

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic ppu_regs_pkg::bus_data_t rand_byte();
        ppu_regs_pkg::bus_data_t b;
        b = '0;
        for (int i = 0; i < 8; i++) begin
            b = {b[6:0], lfsr_bit()};
        end
        return b;
    endfunction

    // Expected descriptor for one pixel
    function automatic ppu_regs_pkg::sprite_pixel_t ref_pixel(
            input ppu_timing_pkg::pixel_coord_t x, input ppu_timing_pkg::pixel_coord_t y);
        ppu_regs_pkg::sprite_pixel_t r;
        ppu_regs_pkg::bus_data_t     attr;
        int sx, sy, h, ex, ey, fx, fy;
        logic found;
        r = '0;
        r.pos.valid = 1'b1;
        r.pos.x = x;
        r.pos.y = y;
        found = 1'b0;
        sx = int'(x) + 8;
        sy = int'(y) + 16;
        h = lcdc_copy[ppu_regs_pkg::lcdc_tall_bit] ? 16 : 8;
        if (lcdc_copy[ppu_regs_pkg::lcdc_sprites_bit]) begin
            for (int i = 0; i < ppu_regs_pkg::sprite_count; i++) begin
                ey = int'(oam_copy[4*i]);
                ex = int'(oam_copy[4*i+1]);
                attr = oam_copy[4*i+3];
                if (!found && sx >= ex && sx < ex + 8 && sy >= ey && sy < ey + h) begin
                    found = 1'b1;
                    fx = attr[5] ? 7 - (sx - ex) : sx - ex;
                    fy = attr[6] ? h - 1 - (sy - ey) : sy - ey;
                    r.index = ppu_regs_pkg::sprite_index_t'(i);
                    r.sprite.hit = 1'b1;
                    r.sprite.fine_x = 3'(fx);
                    r.sprite.fine_y = 4'(fy);
                    r.sprite.tile = oam_copy[4*i+2];
                    r.sprite.palette = attr[4];
                    r.sprite.behind = attr[7];
                end
            end
        end
        return r;
    endfunction

    task automatic stop_run();
        $display("Something failed");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic fail_run(input string what);
        $display("%s", what);
        stop_run();
    endtask

    task automatic check_byte(input string name, input ppu_regs_pkg::bus_data_t got,
                              input ppu_regs_pkg::bus_data_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_pixel(input ppu_regs_pkg::sprite_pixel_t got,
                               input ppu_regs_pkg::sprite_pixel_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t sprite_pixel got %h expected %h", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic check_mode(input ppu_timing_pkg::mode_t got,
                              input ppu_timing_pkg::mode_t exp);
        if (got !== exp) begin
            $display("[ERROR] %0t stat.mode got %0d expected %0d", $time, got, exp);
            stop_run();
        end
    endtask

    // No load during a store, so the read data must sit at zero
    task automatic write_reg(input ppu_regs_pkg::bus_addr_t addr,
                             input ppu_regs_pkg::bus_data_t data);
        @(negedge clockgb);
        address = addr;
        indata  = data;
        store   = 1'b1;
        @(negedge clockgb);
        store = 1'b0;
        if (addr == ppu_regs_pkg::lcdc_addr) lcdc_copy = data;
        check_byte("outdata", outdata, 8'h00);
    endtask

    task automatic read_reg(input ppu_regs_pkg::bus_addr_t addr,
                            output ppu_regs_pkg::bus_data_t data);
        @(negedge clockgb);
        address = addr;
        load    = 1'b1;
        @(negedge clockgb);
        load = 1'b0;
        data = outdata;
    endtask

    // Keeps sprite bits so in-flight pixels still match
    task automatic display_off();
        ppu_regs_pkg::bus_data_t d;
        write_reg(ppu_regs_pkg::lcdc_addr, lcdc_copy & 8'h7f);
        repeat (1000) begin
            @(negedge clockgb);
            if (vblank_int) fail_run("vblank pulse while display disabled");
        end
        read_reg(ppu_regs_pkg::ly_addr, d);
        check_byte("ly", d, 8'h00);
    endtask

    task automatic display_on(input ppu_regs_pkg::bus_data_t value);
        write_reg(ppu_regs_pkg::lcdc_addr, value & 8'h7f);
        write_reg(ppu_regs_pkg::lcdc_addr, value | 8'h80);
    endtask

    always @(posedge clockgb) begin
        cycles <= cycles + 1;
        if (cycles >= timeout_limit) fail_run("Timeout, the run took too many cycles");
    end

    // Pixel, pulse and frame monitor
    always @(negedge clockgb) begin
        if (resetn && !dut0.lcd_ctrl.enable) begin
            exp_x = 0;
            exp_y = 0;
            pix_count = 0;
            last_vb = 0;
        end else if (resetn) begin
            if (sprite_pixel.pos.valid) begin
                if (int'(sprite_pixel.pos.x) != exp_x || int'(sprite_pixel.pos.y) != exp_y)
                    fail_run("Pixel position out of sequence, wrong pixels per line");
                check_pixel(sprite_pixel, ref_pixel(sprite_pixel.pos.x, sprite_pixel.pos.y));
                pix_count++;
                exp_x++;
                if (exp_x == ppu_timing_pkg::screen_width) begin
                    exp_x = 0;
                    exp_y = (exp_y + 1) % ppu_timing_pkg::screen_height;
                end
            end
            if (vblank_int) begin
                vb_count++;
                if (last_vb != 0 && cycles - last_vb != frame_cycles)
                    fail_run("Gap between vblank pulses is not one frame");
                if (pix_count != frame_pixels) fail_run("Wrong number of pixels in a frame");
                pix_count = 0;
                last_vb = cycles;
            end
            if (lcdc_int) lcdc_count++;
        end
    end

    initial begin
        ppu_regs_pkg::bus_data_t d;
        int target;
        int lc0;
        int prev;
        logic wrapped;
        address = '0;
        indata  = '0;
        load    = 1'b0;
        store   = 1'b0;
        lcdc_copy = ppu_regs_pkg::lcdc_reset;
        @(posedge resetn);
        read_reg(ppu_regs_pkg::lcdc_addr, d);
        check_byte("lcdc", d, ppu_regs_pkg::lcdc_reset);
        write_reg(ppu_regs_pkg::lcdc_addr, 8'h02);
        read_reg(ppu_regs_pkg::lcdc_addr, d);
        check_byte("lcdc", d, 8'h02);
        for (int i = 0; i < 160; i++) begin
            oam_copy[i] = rand_byte();
            write_reg(16'(int'(ppu_regs_pkg::oam_base) + i), oam_copy[i]);
        end
        for (int i = 0; i < 160; i += 7) begin
            read_reg(16'(int'(ppu_regs_pkg::oam_base) + i), d);
            check_byte("oam", d, oam_copy[i]);
        end
        write_reg(ppu_regs_pkg::lyc_addr, 8'h00);
        read_reg(ppu_regs_pkg::lyc_addr, d);
        check_byte("lyc", d, 8'h00);
        write_reg(ppu_regs_pkg::stat_addr, 8'h7f);
        read_reg(ppu_regs_pkg::stat_addr, d);
        check_byte("stat", d, 8'h7e);
        check_mode(ppu_timing_pkg::mode_t'(d[1:0]), ppu_timing_pkg::mode_oam_scan);
        write_reg(ppu_regs_pkg::lyc_addr, 8'h05);
        read_reg(ppu_regs_pkg::stat_addr, d);
        check_byte("stat", d, 8'h7a);
        read_reg(ppu_regs_pkg::ly_addr, d);
        check_byte("ly", d, 8'h00);
        read_reg(16'hff00, d);
        check_byte("unmapped", d, 8'h00);
        read_reg(16'hfea0, d);
        check_byte("unmapped", d, 8'h00);

        // Coincidence interrupt on line 10, normal sprites
        write_reg(ppu_regs_pkg::stat_addr, 8'h40);
        write_reg(ppu_regs_pkg::lyc_addr, 8'd10);
        display_on(8'h82);
        do @(negedge clockgb); while (!lcdc_int);
        read_reg(ppu_regs_pkg::ly_addr, d);
        check_byte("ly", d, 8'd10);
        target = vb_count + 1;
        while (vb_count < target) @(negedge clockgb);
        lc0 = lcdc_count;
        prev = 144;
        wrapped = 1'b0;
        while (vb_count < target + 1) begin
            read_reg(ppu_regs_pkg::ly_addr, d);
            if (!(int'(d) == prev || int'(d) == prev + 1 || (prev == 153 && d == 8'd0)))
                fail_run("LY did not advance by one line");
            if (prev == 153 && d == 8'd0) wrapped = 1'b1;
            prev = int'(d);
        end
        if (!wrapped) fail_run("LY never wrapped from 153 to 0");
        if (lcdc_count - lc0 != 1) fail_run("Coincidence interrupt not once per frame");

        // No status sources from here on
        write_reg(ppu_regs_pkg::stat_addr, 8'h00);
        display_off();
        lc0 = lcdc_count;
        display_on(8'h86);
        repeat (20 * line_cycles) @(negedge clockgb);
        display_off();
        for (int s = 0; s < 4; s++) begin
            oam_copy[4*s]   = 8'd66;
            oam_copy[4*s+1] = 8'd58;
            oam_copy[4*s+2] = 8'(s * 16 + 1);
            oam_copy[4*s+3] = 8'(s * 8'h50);
            for (int k = 0; k < 4; k++) begin
                write_reg(16'(int'(ppu_regs_pkg::oam_base) + 4 * s + k), oam_copy[4*s+k]);
            end
        end
        display_on(8'h82);
        repeat (60 * line_cycles) @(negedge clockgb);
        display_off();
        display_on(8'h80);
        repeat (10 * line_cycles) @(negedge clockgb);
        if (lcdc_count != lc0) fail_run("lcdc_int pulsed with all status sources clear");
        $display("Everything OK");
        $finish;
    end

endmodule
